/* Bender.yml */
package:
  name: dcache

sources:
  - src/cache_cfg_pkg.sv
  - src/mem_bus_pkg.sv
  - src/tag_store.sv
  - src/data_store.sv
  - src/line_fill.sv
  - src/line_drain.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_chk.sv
      - sim/tb_dcache.sv

/* dcache.f */
src/cache_cfg_pkg.sv
src/mem_bus_pkg.sv
src/tag_store.sv
src/data_store.sv
src/line_fill.sv
src/line_drain.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/dcache_chk.sv
sim/tb_dcache.sv

/* sim/dcache_chk.sv */
`timescale 1ns/1ps

module dcache_chk (
    input logic                            clk,
    input logic                            rst,
    input logic                            mem_rd_req_valid,
    input logic                            mem_rd_req_ready,
    input logic [31:0]                     mem_rd_req_addr,
    input logic [7:0]                      mem_rd_req_len,
    input logic                            mem_wr_req_valid,
    input logic                            mem_wr_req_ready,
    input logic [31:0]                     mem_wr_req_addr,
    input logic [7:0]                      mem_wr_req_len,
    input logic                            mem_wr_data_valid,
    input logic                            mem_wr_data_ready,
    input logic [mem_bus_pkg::STRB_W-1:0]  mem_wr_data_strb
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    int fail_count = 0;

    // a raised valid waits for its ready
    property held(v, r);
        @(posedge clk) disable iff (rst) v && !r |=> v;
    endproperty

    rd_req_held: assert property (held(mem_rd_req_valid, mem_rd_req_ready))
        else begin
            fail_count++;
            $error("mem_rd_req_valid dropped before its transfer");
        end

    wr_req_held: assert property (held(mem_wr_req_valid, mem_wr_req_ready))
        else begin
            fail_count++;
            $error("mem_wr_req_valid dropped before its transfer");
        end

    wr_data_held: assert property (held(mem_wr_data_valid, mem_wr_data_ready))
        else begin
            fail_count++;
            $error("mem_wr_data_valid dropped before its transfer");
        end

    // whole-line bursts only
    rd_req_line: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req_valid |->
            mem_rd_req_len == BURST_LEN && mem_rd_req_addr[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("read burst is not a full aligned line");
        end

    wr_req_line: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_valid |->
            mem_wr_req_len == BURST_LEN && mem_wr_req_addr[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("write burst is not a full aligned line");
        end

    wr_data_strb: assert property (@(posedge clk) disable iff (rst)
        mem_wr_data_valid |-> mem_wr_data_strb == FULL_STRB)
        else begin
            fail_count++;
            $error("write-back beat without full strobe");
        end

endmodule

bind dcache_top dcache_chk u_chk (.*);

/* sim/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    localparam int NUM_WAYS  = 4;
    localparam int PERIOD    = 40;
    localparam int NUM_TESTS = 5;
    localparam int MEM_AW    = 12;
    localparam logic [31:0] MEM_KEY = 32'hA5C3_0F96;

    logic        clk;
    logic        rst;
    logic        cpu_req_valid;
    logic        cpu_req_write;
    logic [31:0] cpu_req_addr;
    logic [31:0] cpu_req_wdata;
    logic [3:0]  cpu_req_wstrb;
    logic        cpu_req_ready;
    logic        cpu_rsp_valid;
    logic [31:0] cpu_rsp_data;
    logic        cpu_rsp_ready;
    logic        mem_rd_req_valid;
    logic [31:0] mem_rd_req_addr;
    logic [7:0]  mem_rd_req_len;
    logic        mem_rd_req_ready;
    logic        mem_rd_rsp_valid;
    logic [31:0] mem_rd_rsp_data;
    logic        mem_rd_rsp_last;
    logic        mem_rd_rsp_ready;
    logic        mem_wr_req_valid;
    logic [31:0] mem_wr_req_addr;
    logic [7:0]  mem_wr_req_len;
    logic        mem_wr_req_ready;
    logic        mem_wr_data_valid;
    logic [31:0] mem_wr_data;
    logic [3:0]  mem_wr_data_strb;
    logic        mem_wr_data_last;
    logic        mem_wr_data_ready;

    // memory model state
    logic [31:0] shadow  [2**MEM_AW];
    logic        written [2**MEM_AW];
    logic [7:0]  lfsr;
    logic [31:0] rd_base;
    logic [31:0] wr_base;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    logic [7:0]  last_rd_len;
    logic        rd_active;
    int          rd_beat;
    int          wr_beat;
    int          rd_bursts;
    int          wr_bursts;
    int          wr_beats;
    int          wr_beats_at_rd;

    int   errors = 0;
    int   tests = 0;
    logic hit_window = 1'b0;

    dcache_top #(.NUM_WAYS(NUM_WAYS)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(NUM_TESTS * 400 * PERIOD);
        $display("watchdog expired, the DUT stopped answering");
        $display("TEST FAILED");
        $finish;
    end

    // 8-bit Fibonacci, taps 8 6 5 4
    function automatic logic next_bit();
        lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ MEM_KEY;
    endfunction

    // written-back words override the fill pattern
    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        return written[addr[MEM_AW+1:2]] ? shadow[addr[MEM_AW+1:2]] : mem_word(addr);
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++)
            res[b*8 +: 8] = strb[b] ? data[b*8 +: 8] : old[b*8 +: 8];
        return res;
    endfunction

    // transfers seen at the falling edge happen at the next rising edge
    initial begin : memory_model
        logic             rd_req_fire;
        logic             rd_fire;
        logic             wr_req_fire;
        logic             wr_fire;
        logic [MEM_AW-1:0] idx;
        lfsr              = 8'd28;
        mem_rd_req_ready  = 1'b0;
        mem_rd_rsp_valid  = 1'b0;
        mem_rd_rsp_data   = '0;
        mem_rd_rsp_last   = 1'b0;
        mem_wr_req_ready  = 1'b0;
        mem_wr_data_ready = 1'b0;
        rd_active         = 1'b0;
        rd_base           = '0;
        wr_base           = '0;
        rd_beat           = 0;
        wr_beat           = 0;
        rd_bursts         = 0;
        wr_bursts         = 0;
        wr_beats          = 0;
        wr_beats_at_rd    = 0;
        for (int i = 0; i < 2**MEM_AW; i++)
            written[i] = 1'b0;
        forever begin
            @(negedge clk);
            rd_req_fire = mem_rd_req_valid && mem_rd_req_ready;
            rd_fire     = mem_rd_rsp_valid && mem_rd_rsp_ready;
            wr_req_fire = mem_wr_req_valid && mem_wr_req_ready;
            wr_fire     = mem_wr_data_valid && mem_wr_data_ready;
            if (rd_req_fire) begin
                rd_active      = 1'b1;
                rd_base        = mem_rd_req_addr;
                rd_beat        = 0;
                rd_bursts++;
                last_rd_addr   = mem_rd_req_addr;
                last_rd_len    = mem_rd_req_len;
                wr_beats_at_rd = wr_beats;
            end
            if (rd_fire) begin
                rd_beat++;
                if (mem_rd_rsp_last)
                    rd_active = 1'b0;
            end
            if (wr_req_fire) begin
                wr_base      = mem_wr_req_addr;
                wr_beat      = 0;
                wr_bursts++;
                last_wr_addr = mem_wr_req_addr;
            end
            if (wr_fire) begin
                // last marks the eighth beat and no other
                check_value("mem_wr_data_last", wr_beat == 7, mem_wr_data_last);
                idx          = wr_base[MEM_AW+1:2] + MEM_AW'(wr_beat);
                shadow[idx]  = mem_wr_data;
                written[idx] = 1'b1;
                wr_beat++;
                wr_beats++;
            end
            @(posedge clk);
            #1;
            mem_rd_req_ready  = next_bit();
            mem_wr_req_ready  = next_bit();
            mem_wr_data_ready = next_bit();
            // a raised beat holds until it transfers
            if (!mem_rd_rsp_valid || rd_fire)
                mem_rd_rsp_valid = rd_active && next_bit();
            mem_rd_rsp_data = mem_read(rd_base + 32'(rd_beat * 4));
            mem_rd_rsp_last = (rd_beat == 7);
        end
    end

    // hits stay off the memory read channel
    no_refill_on_hit: assert property (@(posedge clk) disable iff (rst)
        hit_window |-> !mem_rd_req_valid)
        else begin
            $display("** Error at %0d ns: mem_rd_req_valid expected 0 got 1", $time);
            errors++;
        end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic send_req(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b1;
        cpu_req_write = wr;
        cpu_req_addr  = addr;
        cpu_req_wdata = data;
        cpu_req_wstrb = strb;
        do
            @(negedge clk);
        while (!cpu_req_ready);
        @(posedge clk);
        #1;
        cpu_req_valid = 1'b0;
    endtask

    // latency counts rising edges after the accepting one
    task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data,
                            output int latency);
        send_req(1'b0, addr, '0, '0);
        latency = 0;
        @(negedge clk);
        while (!cpu_rsp_valid) begin
            latency++;
            @(negedge clk);
        end
        data = cpu_rsp_data;
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output int latency);
        send_req(1'b1, addr, data, strb);
        latency = 0;
        @(negedge clk);
        while (!cpu_req_ready) begin
            latency++;
            @(negedge clk);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        $display("%s: %s", name, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin : stimulus
        logic [31:0] data;
        logic [31:0] line_addr;
        int          lat;
        int          e0;
        int          rb;
        int          wb;
        int          beats0;
        int          chk_errors;
        cpu_req_valid = 1'b0;
        cpu_req_write = 1'b0;
        cpu_req_addr  = '0;
        cpu_req_wdata = '0;
        cpu_req_wstrb = '0;
        cpu_rsp_ready = 1'b1;
        rst           = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        e0 = errors;
        rb = rd_bursts;
        cpu_read(32'h0000_1234, data, lat);
        check_value("cpu_rsp_data", mem_word(32'h0000_1234), data);
        check_value("read bursts", rb + 1, rd_bursts);
        check_value("mem_rd_req_addr", 32'h0000_1220, last_rd_addr);
        check_value("mem_rd_req_len", 8'd7, last_rd_len);
        end_test("read miss", e0);

        e0 = errors;
        hit_window = 1'b1;
        cpu_read(32'h0000_1228, data, lat);
        hit_window = 1'b0;
        check_value("cpu_rsp_data", mem_word(32'h0000_1228), data);
        check_value("read hit latency", 2, lat);
        end_test("read hit", e0);

        e0 = errors;
        hit_window = 1'b1;
        cpu_write(32'h0000_123C, 32'hDEAD_BEEF, 4'b0101, lat);
        check_value("write hit latency", 3, lat);
        cpu_read(32'h0000_123C, data, lat);
        hit_window = 1'b0;
        check_value("cpu_rsp_data",
                    merge(mem_word(32'h0000_123C), 32'hDEAD_BEEF, 4'b0101), data);
        end_test("write hit", e0);

        e0 = errors;
        rb = rd_bursts;
        cpu_write(32'h0000_2468, 32'h1357_9BDF, 4'b1100, lat);
        check_value("read bursts", rb + 1, rd_bursts);
        check_value("mem_rd_req_addr", 32'h0000_2460, last_rd_addr);
        cpu_read(32'h0000_2468, data, lat);
        check_value("cpu_rsp_data",
                    merge(mem_word(32'h0000_2468), 32'h1357_9BDF, 4'b1100), data);
        end_test("write miss", e0);

        // fill every way of set 6, dirty the first line, then one more miss
        e0 = errors;
        wb = wr_bursts;
        cpu_read(32'h0000_00C4, data, lat);
        check_value("cpu_rsp_data", mem_word(32'h0000_00C4), data);
        cpu_write(32'h0000_00CC, 32'hCAFE_F00D, 4'b0011, lat);
        for (int i = 1; i < NUM_WAYS; i++)
            cpu_read(32'h0000_00C0 + 32'(i * 32'h100), data, lat);
        check_value("write bursts", wb, wr_bursts);
        beats0 = wr_beats;
        cpu_read(32'h0000_00C0 + 32'(NUM_WAYS * 32'h100), data, lat);
        check_value("write bursts", wb + 1, wr_bursts);
        check_value("mem_wr_req_addr", 32'h0000_00C0, last_wr_addr);
        check_value("beats before refill", beats0 + 8, wr_beats_at_rd);
        for (int w = 0; w < 8; w++) begin
            line_addr = 32'h0000_00C0 + 32'(w * 4);
            check_value("mem_wr_data",
                        (w == 3) ? merge(mem_word(line_addr), 32'hCAFE_F00D, 4'b0011)
                                 : mem_word(line_addr),
                        shadow[line_addr[MEM_AW+1:2]]);
        end
        cpu_read(32'h0000_00CC, data, lat);
        check_value("cpu_rsp_data",
                    merge(mem_word(32'h0000_00CC), 32'hCAFE_F00D, 4'b0011), data);
        end_test("dirty eviction", e0);

        chk_errors = uut.u_chk.fail_count;
        $display("tests %0d, check errors %0d, protocol errors %0d",
                 tests, errors, chk_errors);
        if (errors == 0 && chk_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* src/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    // geometry of the 4-way, 8-set cache
    localparam int NUM_SETS       = 8;
    localparam int LINE_BYTES     = 32;
    localparam int WORDS_PER_LINE = LINE_BYTES / 4;
    localparam int LINE_W         = LINE_BYTES * 8;
    localparam int OFFSET_W       = $clog2(LINE_BYTES);
    localparam int INDEX_W        = $clog2(NUM_SETS);
    localparam int TAG_W          = 32 - INDEX_W - OFFSET_W;

    // field view of a byte address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-3:0] word;
        logic [1:0]          byte_off;
    } cache_fields_t;

    // raw word toward memory, fields for lookup
    typedef union packed {
        logic [31:0]   raw;
        cache_fields_t f;
    } cache_addr_u;

endpackage

/* src/data_store.sv */
`timescale 1ns/1ps

module data_store #(
    parameter int NUM_WAYS = 4
) (
    input  logic                              clk,
    input  cache_cfg_pkg::cache_addr_u        lookup_addr,
    input  logic [$clog2(NUM_WAYS)-1:0]       hit_way,
    input  logic [$clog2(NUM_WAYS)-1:0]       victim_way,
    input  logic                              data_wen,
    input  logic [$clog2(NUM_WAYS)-1:0]       wr_way,
    input  logic                              fill_sel,
    input  logic                              merge_en,
    input  logic [cache_cfg_pkg::LINE_W-1:0]  fill_line,
    input  logic [mem_bus_pkg::WORD_W-1:0]    wdata,
    input  logic [mem_bus_pkg::STRB_W-1:0]    wstrb,
    output logic [mem_bus_pkg::WORD_W-1:0]    read_word,
    output logic [cache_cfg_pkg::LINE_W-1:0]  victim_line
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    logic [LINE_W-1:0] line_q [NUM_WAYS][NUM_SETS];
    logic [LINE_W-1:0] src_line;
    logic [LINE_W-1:0] new_line;
    logic [WORD_W-1:0] merged;

    always_comb begin
        // fresh refill line or the stored hit line
        src_line  = fill_sel ? fill_line : line_q[hit_way][lookup_addr.f.index];
        read_word = src_line[lookup_addr.f.word*WORD_W +: WORD_W];
        for (int b = 0; b < STRB_W; b++)
            merged[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : read_word[b*8 +: 8];
        new_line = src_line;
        if (merge_en)
            new_line[lookup_addr.f.word*WORD_W +: WORD_W] = merged;
    end

    always_ff @(posedge clk) begin
        if (data_wen)
            line_q[wr_way][lookup_addr.f.index] <= new_line;
    end

    assign victim_line = line_q[victim_way][lookup_addr.f.index];

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int NUM_WAYS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 cpu_req_valid,
    input  logic                                 cpu_req_write,
    input  logic [31:0]                          cpu_req_addr,
    input  logic [mem_bus_pkg::WORD_W-1:0]       cpu_req_wdata,
    input  logic [mem_bus_pkg::STRB_W-1:0]       cpu_req_wstrb,
    output logic                                 cpu_req_ready,
    output logic                                 cpu_rsp_valid,
    output logic [mem_bus_pkg::WORD_W-1:0]       cpu_rsp_data,
    input  logic                                 cpu_rsp_ready,
    output logic                                 mem_rd_req_valid,
    output logic [31:0]                          mem_rd_req_addr,
    output logic [7:0]                           mem_rd_req_len,
    input  logic                                 mem_rd_req_ready,
    output logic                                 mem_wr_req_valid,
    output logic [31:0]                          mem_wr_req_addr,
    output logic [7:0]                           mem_wr_req_len,
    input  logic                                 mem_wr_req_ready,
    output cache_cfg_pkg::cache_addr_u           lookup_addr,
    input  logic                                 hit,
    input  logic [$clog2(NUM_WAYS)-1:0]          hit_way,
    input  logic                                 victim_dirty,
    input  logic [cache_cfg_pkg::TAG_W-1:0]      victim_tag,
    output logic [$clog2(NUM_WAYS)-1:0]          victim_way,
    output logic                                 tag_wen,
    output logic                                 data_wen,
    output logic [$clog2(NUM_WAYS)-1:0]          wr_way,
    output logic                                 fill_sel,
    output logic                                 merge_en,
    output logic                                 mark_dirty,
    output logic [mem_bus_pkg::WORD_W-1:0]       wdata,
    output logic [mem_bus_pkg::STRB_W-1:0]       wstrb,
    output logic                                 fill_active,
    input  logic                                 fill_done,
    output logic                                 drain_start,
    input  logic                                 drain_done,
    input  logic [mem_bus_pkg::WORD_W-1:0]       read_word
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    typedef enum logic [3:0] {
        ST_IDLE, ST_LOOKUP, ST_HIT_RD, ST_HIT_WR, ST_VICTIM, ST_WB_REQ,
        ST_DRAIN, ST_RD_REQ, ST_FILL, ST_INSTALL, ST_RESP
    } state_t;

    state_t             state;
    logic               ready_q;
    logic [WAY_W-1:0]   victim_ptr;
    cache_addr_u        req_addr;
    logic               req_write;
    logic [WORD_W-1:0]  req_wdata;
    logic [STRB_W-1:0]  req_wstrb;
    logic [WORD_W-1:0]  rsp_data;
    cache_addr_u        line_addr;
    cache_addr_u        wb_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            ready_q    <= 1'b0;
            victim_ptr <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ready_q && cpu_req_valid) begin
                        ready_q <= 1'b0;
                        state   <= ST_LOOKUP;
                    end else begin
                        ready_q <= 1'b1;
                    end
                end
                ST_LOOKUP: begin
                    if (hit)
                        state <= req_write ? ST_HIT_WR : ST_HIT_RD;
                    else
                        state <= ST_VICTIM;
                end
                ST_HIT_RD: state <= ST_RESP;
                ST_HIT_WR: state <= ST_RESP;
                ST_VICTIM: state <= victim_dirty ? ST_WB_REQ : ST_RD_REQ;
                ST_WB_REQ: if (mem_wr_req_ready) state <= ST_DRAIN;
                ST_DRAIN:  if (drain_done) state <= ST_RD_REQ;
                ST_RD_REQ: if (mem_rd_req_ready) state <= ST_FILL;
                ST_FILL:   if (fill_done) state <= ST_INSTALL;
                ST_INSTALL: begin
                    // one step per miss, wraps at the last way
                    if (victim_ptr == WAY_W'(NUM_WAYS - 1))
                        victim_ptr <= '0;
                    else
                        victim_ptr <= victim_ptr + 1'b1;
                    // write-allocate merges into the new line next
                    state <= req_write ? ST_HIT_WR : ST_RESP;
                end
                ST_RESP: begin
                    if (req_write || cpu_rsp_ready) begin
                        ready_q <= 1'b1;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && ready_q && cpu_req_valid) begin
            req_addr  <= cpu_req_addr;
            req_write <= cpu_req_write;
            req_wdata <= cpu_req_wdata;
            req_wstrb <= cpu_req_wstrb;
        end
        if (state == ST_HIT_RD || state == ST_INSTALL)
            rsp_data <= read_word;
    end

    // line addresses for refill and write-back
    always_comb begin
        line_addr            = req_addr;
        line_addr.f.word     = '0;
        line_addr.f.byte_off = '0;
        wb_addr              = line_addr;
        wb_addr.f.tag        = victim_tag;
    end

    assign cpu_req_ready    = ready_q;
    assign cpu_rsp_valid    = (state == ST_RESP) && !req_write;
    assign cpu_rsp_data     = rsp_data;

    assign mem_rd_req_valid = (state == ST_RD_REQ);
    assign mem_rd_req_addr  = line_addr.raw;
    assign mem_rd_req_len   = BURST_LEN;
    assign mem_wr_req_valid = (state == ST_WB_REQ);
    assign mem_wr_req_addr  = wb_addr.raw;
    assign mem_wr_req_len   = BURST_LEN;

    assign lookup_addr = req_addr;
    assign victim_way  = victim_ptr;
    assign tag_wen     = (state == ST_INSTALL) || (state == ST_HIT_WR);
    assign data_wen    = tag_wen;
    assign wr_way      = (state == ST_INSTALL) ? victim_ptr : hit_way;
    assign fill_sel    = (state == ST_INSTALL);
    assign merge_en    = (state == ST_HIT_WR);
    assign mark_dirty  = (state == ST_HIT_WR);
    assign wdata       = req_wdata;
    assign wstrb       = req_wstrb;
    assign fill_active = (state == ST_FILL);
    // capture the victim as the write request goes out
    assign drain_start = (state == ST_WB_REQ) && mem_wr_req_ready;

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
    parameter int NUM_WAYS = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             cpu_req_valid,
    input  logic                             cpu_req_write,
    input  logic [31:0]                      cpu_req_addr,
    input  logic [mem_bus_pkg::WORD_W-1:0]   cpu_req_wdata,
    input  logic [mem_bus_pkg::STRB_W-1:0]   cpu_req_wstrb,
    output logic                             cpu_req_ready,
    output logic                             cpu_rsp_valid,
    output logic [mem_bus_pkg::WORD_W-1:0]   cpu_rsp_data,
    input  logic                             cpu_rsp_ready,
    output logic                             mem_rd_req_valid,
    output logic [31:0]                      mem_rd_req_addr,
    output logic [7:0]                       mem_rd_req_len,
    input  logic                             mem_rd_req_ready,
    input  logic                             mem_rd_rsp_valid,
    input  logic [mem_bus_pkg::WORD_W-1:0]   mem_rd_rsp_data,
    input  logic                             mem_rd_rsp_last,
    output logic                             mem_rd_rsp_ready,
    output logic                             mem_wr_req_valid,
    output logic [31:0]                      mem_wr_req_addr,
    output logic [7:0]                       mem_wr_req_len,
    input  logic                             mem_wr_req_ready,
    output logic                             mem_wr_data_valid,
    output logic [mem_bus_pkg::WORD_W-1:0]   mem_wr_data,
    output logic [mem_bus_pkg::STRB_W-1:0]   mem_wr_data_strb,
    output logic                             mem_wr_data_last,
    input  logic                             mem_wr_data_ready
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    // lookup and victim status
    cache_addr_u        lookup_addr;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [WAY_W-1:0]   victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;

    // store write controls
    logic               tag_wen;
    logic               data_wen;
    logic [WAY_W-1:0]   wr_way;
    logic               fill_sel;
    logic               merge_en;
    logic               mark_dirty;
    logic [WORD_W-1:0]  wdata;
    logic [STRB_W-1:0]  wstrb;
    logic [WORD_W-1:0]  read_word;

    // burst engines
    logic [LINE_W-1:0]  fill_line;
    logic [LINE_W-1:0]  victim_line;
    logic               fill_active;
    logic               fill_done;
    logic               drain_start;
    logic               drain_done;

    dcache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (.*);

    tag_store #(.NUM_WAYS(NUM_WAYS)) u_tags (.*);

    data_store #(.NUM_WAYS(NUM_WAYS)) u_data (.*);

    line_fill u_fill (.*);

    line_drain u_drain (.*);

endmodule

/* src/line_drain.sv */
`timescale 1ns/1ps

module line_drain (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              drain_start,
    input  logic [cache_cfg_pkg::LINE_W-1:0]  victim_line,
    output logic                              mem_wr_data_valid,
    output logic [mem_bus_pkg::WORD_W-1:0]    mem_wr_data,
    output logic [mem_bus_pkg::STRB_W-1:0]    mem_wr_data_strb,
    output logic                              mem_wr_data_last,
    input  logic                              mem_wr_data_ready,
    output logic                              drain_done
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int CNT_W = $clog2(WORDS_PER_LINE);

    logic [LINE_W-1:0] shift_q;
    logic [CNT_W-1:0]  beat_q;
    logic              active_q;
    logic              beat;

    assign beat = active_q && mem_wr_data_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            beat_q   <= '0;
        end else if (drain_start) begin
            active_q <= 1'b1;
            beat_q   <= '0;
        end else if (beat) begin
            beat_q <= beat_q + 1'b1;
            if (mem_wr_data_last)
                active_q <= 1'b0;
        end
    end

    // low word goes out first
    always_ff @(posedge clk) begin
        if (drain_start)
            shift_q <= victim_line;
        else if (beat)
            shift_q <= shift_q >> WORD_W;
    end

    assign mem_wr_data_valid = active_q;
    assign mem_wr_data       = shift_q[WORD_W-1:0];
    assign mem_wr_data_strb  = FULL_STRB;
    assign mem_wr_data_last  = (beat_q == CNT_W'(WORDS_PER_LINE - 1));
    assign drain_done        = beat && mem_wr_data_last;

endmodule

/* src/line_fill.sv */
`timescale 1ns/1ps

module line_fill (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              mem_rd_rsp_valid,
    input  logic [mem_bus_pkg::WORD_W-1:0]    mem_rd_rsp_data,
    input  logic                              mem_rd_rsp_last,
    output logic                              mem_rd_rsp_ready,
    input  logic                              fill_active,
    output logic [cache_cfg_pkg::LINE_W-1:0]  fill_line,
    output logic                              fill_done
);
    import cache_cfg_pkg::*;
    import mem_bus_pkg::*;

    localparam int CNT_W = $clog2(WORDS_PER_LINE);

    logic [CNT_W-1:0] beat_q;
    logic             beat;

    assign mem_rd_rsp_ready = fill_active;
    assign beat             = mem_rd_rsp_valid && fill_active;
    assign fill_done        = beat && mem_rd_rsp_last;

    always_ff @(posedge clk) begin
        if (rst)
            beat_q <= '0;
        else if (beat)
            beat_q <= mem_rd_rsp_last ? '0 : beat_q + 1'b1;
    end

    // word n of the burst lands at word n of the line
    always_ff @(posedge clk) begin
        if (beat)
            fill_line[beat_q*WORD_W +: WORD_W] <= mem_rd_rsp_data;
    end

endmodule

/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

    // one data beat on the memory channels
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;

    // len field of a line burst, eight beats
    localparam logic [7:0] BURST_LEN = 8'd7;

    // write-back always stores whole words
    localparam logic [STRB_W-1:0] FULL_STRB = '1;

endpackage

/* src/tag_store.sv */
`timescale 1ns/1ps

module tag_store #(
    parameter int NUM_WAYS = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_cfg_pkg::cache_addr_u       lookup_addr,
    input  logic                             tag_wen,
    input  logic [$clog2(NUM_WAYS)-1:0]      wr_way,
    input  logic                             mark_dirty,
    input  logic [$clog2(NUM_WAYS)-1:0]      victim_way,
    output logic                             hit,
    output logic [$clog2(NUM_WAYS)-1:0]      hit_way,
    output logic                             victim_dirty,
    output logic [cache_cfg_pkg::TAG_W-1:0]  victim_tag
);
    import cache_cfg_pkg::*;

    localparam int WAY_W = $clog2(NUM_WAYS);

    logic [TAG_W-1:0]    tag_q   [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else if (tag_wen) begin
            valid_q[wr_way][lookup_addr.f.index] <= 1'b1;
            dirty_q[wr_way][lookup_addr.f.index] <= mark_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_wen)
            tag_q[wr_way][lookup_addr.f.index] <= lookup_addr.f.tag;
    end

    // compare all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[w][lookup_addr.f.index] &&
                tag_q[w][lookup_addr.f.index] == lookup_addr.f.tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    assign victim_dirty = dirty_q[victim_way][lookup_addr.f.index];
    assign victim_tag   = tag_q[victim_way][lookup_addr.f.index];

endmodule
